// File: Makefile
# Verilator build and run of the execute path testbench
# Override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_rv_exec
FLIST     ?= project.f
BUILD_DIR ?= build
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard hw/*.sv hw/*.svh dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/tb_rv_exec.sv
// Self-checking testbench for the RV32I execute path
// Drives credit-controlled instructions and compares every result record
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module tb_rv_exec;

  localparam int QD             = `RV_QUEUE_DEPTH;
  localparam int RC             = `RV_RES_CREDITS;
  localparam int TIMEOUT_CYCLES = 200;

  logic        clk_i = 1'b0;
  logic        rstn_i;
  logic        instr_valid_i;
  logic [31:0] instr_i;
  logic        instr_credit_o;
  logic        res_valid_o;
  logic [4:0]  res_rd_o;
  logic [31:0] res_data_o;
  logic        res_illegal_o;
  logic        res_credit_i = 1'b0;

  // Reference state and expected records {illegal, rd, data}
  logic [31:0] model_regs [32];
  logic [37:0] exp_q [$];

  // Sender side credit bookkeeping
  int          credits_returned = 0;
  int          credits_spent    = 0;
  // Consumer side bookkeeping
  int          records_seen     = 0;
  int          credits_given    = 0;
  logic        hold_credits     = 1'b0;
  logic [7:0]  credit_mask      = 8'hff;
  logic [2:0]  credit_phase     = 3'd0;

  int          check_count = 0;
  int          error_count = 0;

  rv_exec_top uut (
    .clk_i, .rstn_i, .instr_valid_i, .instr_i, .instr_credit_o,
    .res_valid_o, .res_rd_o, .res_data_o, .res_illegal_o, .res_credit_i
  );

  always #5 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Checking helpers
  //////////////////////////////////////////////////
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error: %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $finish;
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (error_count == errs_before) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: FAILED with %0d errors", name, error_count - errs_before);
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model applying RV32I rules in program order
  //////////////////////////////////////////////////
  function automatic void ref_model(input logic [31:0] instr, output logic [37:0] rec);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        bad;
    opc = instr[6:0];
    f3  = instr[14:12];
    f7  = instr[31:25];
    rd  = instr[11:7];
    a   = model_regs[instr[19:15]];
    b   = model_regs[instr[24:20]];
    res = 32'd0;
    if (opc == 7'b0010011) begin
      // I-type immediate replaces rs2
      b = {{20{instr[31]}}, instr[31:20]};
      if (f3 == 3'd1) begin
        bad = (f7 != 7'h00);
      end else if (f3 == 3'd5) begin
        bad = !((f7 == 7'h00) || (f7 == 7'h20));
      end else begin
        bad = 1'b0;
      end
    end else if (opc == 7'b0110011) begin
      bad = !((f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5))));
    end else begin
      bad = 1'b1;
    end
    case (f3)
      3'd0:    res = ((opc == 7'b0110011) && f7[5]) ? a - b : a + b;
      3'd1:    res = a << b[4:0];
      3'd2:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    res = (a < b) ? 32'd1 : 32'd0;
      3'd4:    res = a ^ b;
      3'd5:    res = f7[5] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    res = a | b;
      default: res = a & b;
    endcase
    // Illegal leaves no trace and x0 stays zero
    if (bad) begin
      res = 32'd0;
    end else if (rd != 5'd0) begin
      model_regs[rd] = res;
    end
    rec = {bad, rd, res};
  endfunction

  //////////////////////////////////////////////////
  // Instruction encoding
  //////////////////////////////////////////////////
  function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  // Kinds 0..9 are register ops and 10..18 immediate ops
  function automatic logic [31:0] alu_instr(input int kind, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [4:0] rs2);
    logic [2:0]  f3;
    logic [11:0] imm;
    imm = 12'($urandom);
    if (kind == 8) begin
      return encode_r(7'h20, rs2, rs1, 3'd0, rd);
    end
    if (kind == 9) begin
      return encode_r(7'h20, rs2, rs1, 3'd5, rd);
    end
    if (kind < 8) begin
      return encode_r(7'h00, rs2, rs1, 3'(kind), rd);
    end
    if (kind == 18) begin
      return encode_i({7'h20, imm[4:0]}, rs1, 3'd5, rd);
    end
    f3 = 3'(kind - 10);
    // SLLI and SRLI take a plain shift amount
    if ((f3 == 3'd1) || (f3 == 3'd5)) begin
      imm = {7'h00, imm[4:0]};
    end
    return encode_i(imm, rs1, f3, rd);
  endfunction

  function automatic logic [31:0] random_alu(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
    return alu_instr(int'($urandom_range(18, 0)), rd, rs1, rs2);
  endfunction

  //////////////////////////////////////////////////
  // Stimulus and waits
  //////////////////////////////////////////////////
  task automatic send_instr(input logic [31:0] instr);
    int          waited;
    logic [37:0] rec;
    waited = 0;
    @(posedge clk_i);
    // Stall until the sender holds a credit
    while (QD + credits_returned - credits_spent <= 0) begin
      instr_valid_i <= 1'b0;
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        abort_run("Timeout waiting for an input credit");
      end
      @(posedge clk_i);
    end
    instr_valid_i <= 1'b1;
    instr_i       <= instr;
    credits_spent++;
    ref_model(instr, rec);
    exp_q.push_back(rec);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      instr_valid_i <= 1'b0;
    end
  endtask

  // All results in and all result credits handed back
  task automatic drain(input string what);
    int waited;
    waited = 0;
    do begin
      @(posedge clk_i);
      instr_valid_i <= 1'b0;
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        abort_run($sformatf("Timeout waiting for the %s results to drain", what));
      end
    end while ((exp_q.size() != 0) || (credits_given != records_seen));
    check_value("instr_credit_o pulses", credits_returned, credits_spent);
  endtask

  //////////////////////////////////////////////////
  // Monitors sampled mid-cycle
  //////////////////////////////////////////////////
  always @(negedge clk_i) begin
    if (rstn_i && instr_credit_o) begin
      credits_returned++;
    end
  end

  always @(negedge clk_i) begin
    logic [37:0] rec;
    if (rstn_i && res_valid_o) begin
      records_seen++;
      if (exp_q.size() == 0) begin
        error_count++;
        $display("Result record for rd %0d arrived with no instruction outstanding",
                 res_rd_o);
      end else begin
        rec = exp_q.pop_front();
        check_value("res_rd_o", 32'(res_rd_o), 32'(rec[36:32]));
        check_value("res_data_o", res_data_o, rec[31:0]);
        check_value("res_illegal_o", 32'(res_illegal_o), 32'(rec[37]));
      end
    end
  end

  // Consumer hands back one credit per record when the rotating mask allows
  always @(posedge clk_i) begin
    credit_phase <= credit_phase + 3'd1;
    if (!rstn_i) begin
      res_credit_i <= 1'b0;
    end else if (!hold_credits && (credits_given < records_seen) &&
                 credit_mask[credit_phase]) begin
      res_credit_i  <= 1'b1;
      credits_given <= credits_given + 1;
    end else begin
      res_credit_i <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////
  task automatic reset_credit_test();
    int errs;
    errs = error_count;
    idle_cycles(3);
    check_value("instr_credit_o pulses before issue", credits_returned, 0);
    // Full credit burst where each ADDI seeds a register
    for (int i = 0; i < QD; i++) begin
      send_instr(encode_i(12'($urandom), 5'd0, 3'd0, 5'(i + 1)));
    end
    drain("reset credit");
    report_test("credits after reset", errs);
  endtask

  task automatic random_op_test();
    int errs;
    errs = error_count;
    credit_mask <= 8'($urandom) | 8'h01;
    for (int r = 1; r < 32; r++) begin
      send_instr(encode_i(12'($urandom), 5'd0, 3'd0, 5'(r)));
    end
    // Every kind once and then a random mix
    for (int k = 0; k < 19; k++) begin
      send_instr(alu_instr(k, 5'($urandom_range(31, 1)), 5'($urandom), 5'($urandom)));
    end
    for (int i = 0; i < 80; i++) begin
      send_instr(random_alu(5'($urandom_range(31, 1)), 5'($urandom), 5'($urandom)));
    end
    drain("random op");
    report_test("random ALU ops", errs);
  endtask

  task automatic bypass_chain_test();
    int         errs;
    logic [4:0] rd;
    errs = error_count;
    credit_mask <= 8'hff;
    // rd repeats every d instructions, so each reads the result from d back
    for (int d = 1; d <= 3; d++) begin
      for (int i = 0; i < 12; i++) begin
        rd = 5'(16 + (i % d));
        if (i % 2 == 1) begin
          // Register op taking the chained rd on port B
          send_instr(alu_instr(int'($urandom_range(9, 0)), rd,
                               5'($urandom_range(15, 1)), rd));
        end else begin
          send_instr(random_alu(rd, rd, 5'($urandom_range(15, 1))));
        end
      end
      drain($sformatf("distance %0d chain", d));
    end
    report_test("dependent chains", errs);
  endtask

  task automatic x0_write_test();
    int errs;
    errs = error_count;
    send_instr(encode_i(12'h123, 5'd5, 3'd0, 5'd0));
    send_instr(encode_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd6));
    send_instr(encode_r(7'h00, 5'd3, 5'd0, 3'd6, 5'd7));
    send_instr(encode_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
    send_instr(encode_r(7'h00, 5'd9, 5'd0, 3'd3, 5'd8));
    drain("x0 write");
    send_instr(encode_i(12'h000, 5'd0, 3'd6, 5'd12));
    drain("x0 readback");
    report_test("writes to x0", errs);
  endtask

  task automatic backpressure_test();
    int errs;
    int base;
    errs = error_count;
    hold_credits <= 1'b1;
    base = records_seen;
    // Fills the result credits plus the queue
    for (int i = 0; i < RC + QD; i++) begin
      send_instr(random_alu(5'($urandom_range(31, 1)), 5'($urandom), 5'($urandom)));
    end
    idle_cycles(30);
    check_value("records while credits held", records_seen - base, RC);
    hold_credits <= 1'b0;
    credit_mask  <= 8'($urandom) | 8'h01;
    drain("back-pressure");
    check_value("records after release", records_seen - base, RC + QD);
    report_test("result back-pressure", errs);
  endtask

  task automatic illegal_encoding_test();
    int errs;
    errs = error_count;
    send_instr(encode_i(12'h0a5, 5'd0, 3'd0, 5'd9));
    send_instr({12'h004, 5'd1, 3'd2, 5'd9, 7'b0000011});
    send_instr(encode_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd9));
    send_instr(encode_r(7'h20, 5'd2, 5'd1, 3'd1, 5'd9));
    send_instr(encode_i({7'h20, 5'd3}, 5'd1, 3'd1, 5'd9));
    send_instr(encode_i({7'h01, 5'd3}, 5'd1, 3'd5, 5'd9));
    send_instr({20'h12345, 5'd9, 7'b0110111});
    send_instr(32'hffff_ffff);
    // x9 must still hold the ADDI value
    send_instr(encode_r(7'h00, 5'd0, 5'd9, 3'd0, 5'd10));
    send_instr(encode_r(7'h00, 5'd9, 5'd0, 3'd6, 5'd11));
    drain("illegal encoding");
    report_test("illegal encodings", errs);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    void'($urandom(32'hde4f_fb6a));
    rstn_i        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = 32'd0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = 32'd0;
    end
    repeat (8) @(posedge clk_i);
    rstn_i <= 1'b1;

    reset_credit_test();
    random_op_test();
    bypass_chain_test();
    x0_write_test();
    backpressure_test();
    illegal_encoding_test();

    $display("Finished with %0d checks and %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: hw/rv_core_defs.svh
// Size macros for the RV32I execute path
// Include in any file that sizes ports or storage
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// Register and operand width
`define RV_DATA_WIDTH 32

// Register index width, 32 integer registers
`define RV_REG_ADDR_WIDTH 5

// Instruction queue entries
// Also the input credits the sender owns after reset
`define RV_QUEUE_DEPTH 4

// Result records the core may send before credits come back
`define RV_RES_CREDITS 4

`endif

// File: hw/rv_core_pkg.sv
// Shared types of the execute path
// Referenced by scoped name from the decoder, execute stage and top
package rv_core_pkg;

  //////////////////////////////////////////////////
  // ALU operations
  //////////////////////////////////////////////////
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  //////////////////////////////////////////////////
  // Major opcodes, instr[6:0]
  //////////////////////////////////////////////////
  // Register-register ALU group
  // Register-immediate ALU group
  // Any other value decodes as illegal
  typedef enum logic [6:0] {
    MAJ_OP     = 7'b0110011,
    MAJ_OP_IMM = 7'b0010011,
    MAJ_OTHER  = 7'b0000000
  } major_op_e;

endpackage

// File: hw/rv_decoder.sv
// Decode stage for OP and OP_IMM, with operand read and bypass
// Purely combinational, the execute register samples its outputs
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_decoder (
  input  logic                          issue_valid_i,
  input  logic [31:0]                   issue_instr_i,
  // Register file reads
  output logic [`RV_REG_ADDR_WIDTH-1:0] rpa_addr_o,
  input  logic [`RV_DATA_WIDTH-1:0]     rpa_data_i,
  output logic [`RV_REG_ADDR_WIDTH-1:0] rpb_addr_o,
  input  logic [`RV_DATA_WIDTH-1:0]     rpb_data_i,
  // Bypass from execute and writeback
  input  logic [`RV_REG_ADDR_WIDTH-1:0] ex_fwd_rd_i,
  input  logic                          ex_fwd_we_i,
  input  logic [`RV_DATA_WIDTH-1:0]     ex_fwd_data_i,
  input  logic [`RV_REG_ADDR_WIDTH-1:0] wb_fwd_rd_i,
  input  logic                          wb_fwd_we_i,
  input  logic [`RV_DATA_WIDTH-1:0]     wb_fwd_data_i,
  // Decoded instruction
  output logic                          dec_valid_o,
  output logic [`RV_REG_ADDR_WIDTH-1:0] dec_rd_o,
  output logic                          dec_we_o,
  output rv_core_pkg::alu_op_e          dec_op_o,
  output logic [`RV_DATA_WIDTH-1:0]     dec_a_o,
  output logic [`RV_DATA_WIDTH-1:0]     dec_b_o,
  output logic                          dec_illegal_o
);

  localparam int DW      = `RV_DATA_WIDTH;
  localparam int AW      = `RV_REG_ADDR_WIDTH;
  localparam int SHAMT_W = $clog2(DW);

  logic [AW-1:0]        rs1;
  logic [AW-1:0]        rs2;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  logic [DW-1:0]        imm;
  logic                 use_imm;
  logic                 illegal;
  rv_core_pkg::alu_op_e op;

  // funct3 to ALU op, alt selects SUB and SRA
  function automatic rv_core_pkg::alu_op_e f3_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
      3'b001:  return rv_core_pkg::ALU_SLL;
      3'b010:  return rv_core_pkg::ALU_SLT;
      3'b011:  return rv_core_pkg::ALU_SLTU;
      3'b100:  return rv_core_pkg::ALU_XOR;
      3'b101:  return alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
      3'b110:  return rv_core_pkg::ALU_OR;
      default: return rv_core_pkg::ALU_AND;
    endcase
  endfunction

  // Youngest producer wins, x0 never bypassed
  function automatic logic [DW-1:0] bypass(input logic [AW-1:0] src, input logic [DW-1:0] rf);
    if ((src != '0) && ex_fwd_we_i && (ex_fwd_rd_i == src)) begin
      return ex_fwd_data_i;
    end
    if ((src != '0) && wb_fwd_we_i && (wb_fwd_rd_i == src)) begin
      return wb_fwd_data_i;
    end
    return rf;
  endfunction

  // Fixed RV32 field positions
  assign rs1        = issue_instr_i[15 +: AW];
  assign rs2        = issue_instr_i[20 +: AW];
  assign funct3     = issue_instr_i[14:12];
  assign funct7     = issue_instr_i[31:25];
  assign rpa_addr_o = rs1;
  assign rpb_addr_o = rs2;

  always_comb begin
    op      = rv_core_pkg::ALU_ADD;
    use_imm = 1'b0;
    illegal = 1'b0;
    // I-type immediate, sign extended
    imm     = {{(DW-12){issue_instr_i[31]}}, issue_instr_i[31:20]};
    case (rv_core_pkg::major_op_e'(issue_instr_i[6:0]))
      rv_core_pkg::MAJ_OP: begin
        op = f3_op(funct3, funct7[5]);
        // 0100000 only on SUB and SRA
        if (funct7 == 7'b0100000) begin
          illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
        end else begin
          illegal = (funct7 != 7'b0000000);
        end
      end
      rv_core_pkg::MAJ_OP_IMM: begin
        use_imm = 1'b1;
        op      = f3_op(funct3, (funct3 == 3'b101) && funct7[5]);
        // Shifts take shamt and restrict funct7
        if (funct3 == 3'b001) begin
          imm     = DW'(issue_instr_i[20 +: SHAMT_W]);
          illegal = (funct7 != 7'b0000000);
        end else if (funct3 == 3'b101) begin
          imm     = DW'(issue_instr_i[20 +: SHAMT_W]);
          illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
        end
      end
      default: illegal = 1'b1;
    endcase
  end

  // Illegal ops become ADD 0+0, reported with zero data and no write
  assign dec_valid_o   = issue_valid_i;
  assign dec_rd_o      = issue_instr_i[7 +: AW];
  assign dec_we_o      = issue_valid_i && !illegal;
  assign dec_illegal_o = issue_valid_i && illegal;
  assign dec_op_o      = illegal ? rv_core_pkg::ALU_ADD : op;
  assign dec_a_o       = illegal ? '0 : bypass(rs1, rpa_data_i);
  assign dec_b_o       = illegal ? '0 : (use_imm ? imm : bypass(rs2, rpb_data_i));

endmodule

// File: hw/rv_exec_top.sv
// Top of the RV32I integer execute path
// Credit-controlled instruction input and result output
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_exec_top (
  input  logic                          clk_i,
  input  logic                          rstn_i,
  // Instruction stream
  input  logic                          instr_valid_i,
  input  logic [31:0]                   instr_i,
  output logic                          instr_credit_o,
  // Result stream
  output logic                          res_valid_o,
  output logic [`RV_REG_ADDR_WIDTH-1:0] res_rd_o,
  output logic [`RV_DATA_WIDTH-1:0]     res_data_o,
  output logic                          res_illegal_o,
  input  logic                          res_credit_i
);

  // Queue to decoder
  logic                          issue_valid;
  logic [31:0]                   issue_instr;
  // Register file reads
  logic [`RV_REG_ADDR_WIDTH-1:0] rpa_addr;
  logic [`RV_DATA_WIDTH-1:0]     rpa_data;
  logic [`RV_REG_ADDR_WIDTH-1:0] rpb_addr;
  logic [`RV_DATA_WIDTH-1:0]     rpb_data;
  // Decoder to execute
  logic                          dec_valid;
  logic [`RV_REG_ADDR_WIDTH-1:0] dec_rd;
  logic                          dec_we;
  rv_core_pkg::alu_op_e          dec_op;
  logic [`RV_DATA_WIDTH-1:0]     dec_a;
  logic [`RV_DATA_WIDTH-1:0]     dec_b;
  logic                          dec_illegal;
  // Bypass, writeback doubles as register file write
  logic [`RV_REG_ADDR_WIDTH-1:0] ex_rd;
  logic                          ex_we;
  logic [`RV_DATA_WIDTH-1:0]     ex_data;
  logic [`RV_REG_ADDR_WIDTH-1:0] wb_rd;
  logic                          wb_we;
  logic [`RV_DATA_WIDTH-1:0]     wb_data;

  rv_issue_queue u_queue (
    .clk_i, .rstn_i, .instr_valid_i, .instr_i, .instr_credit_o, .res_credit_i,
    .issue_valid_o (issue_valid),
    .issue_instr_o (issue_instr)
  );

  rv_decoder u_decoder (
    .issue_valid_i (issue_valid), .issue_instr_i (issue_instr),
    .rpa_addr_o    (rpa_addr),    .rpa_data_i    (rpa_data),
    .rpb_addr_o    (rpb_addr),    .rpb_data_i    (rpb_data),
    .ex_fwd_rd_i   (ex_rd),       .ex_fwd_we_i   (ex_we),   .ex_fwd_data_i (ex_data),
    .wb_fwd_rd_i   (wb_rd),       .wb_fwd_we_i   (wb_we),   .wb_fwd_data_i (wb_data),
    .dec_valid_o   (dec_valid),   .dec_rd_o      (dec_rd),  .dec_we_o      (dec_we),
    .dec_op_o      (dec_op),      .dec_a_o       (dec_a),   .dec_b_o       (dec_b),
    .dec_illegal_o (dec_illegal)
  );

  rv_regfile u_regfile (
    .clk_i, .rstn_i,
    .rpa_addr_i (rpa_addr), .rpa_data_o (rpa_data),
    .rpb_addr_i (rpb_addr), .rpb_data_o (rpb_data),
    .wpc_addr_i (wb_rd),    .wpc_data_i (wb_data),  .wpc_we_i (wb_we)
  );

  rv_execute u_execute (
    .clk_i, .rstn_i,
    .dec_valid_i   (dec_valid), .dec_rd_i      (dec_rd),  .dec_we_i      (dec_we),
    .dec_op_i      (dec_op),    .dec_a_i       (dec_a),   .dec_b_i       (dec_b),
    .dec_illegal_i (dec_illegal),
    .ex_fwd_rd_o   (ex_rd),     .ex_fwd_we_o   (ex_we),   .ex_fwd_data_o (ex_data),
    .wb_fwd_rd_o   (wb_rd),     .wb_fwd_we_o   (wb_we),   .wb_fwd_data_o (wb_data),
    .res_valid_o, .res_rd_o, .res_data_o, .res_illegal_o
  );

endmodule

// File: hw/rv_execute.sv
// Execute and writeback stages with the ALU between them
// Writeback drives both the register file write and the result record
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_execute (
  input  logic                          clk_i,
  input  logic                          rstn_i,
  // From the decoder
  input  logic                          dec_valid_i,
  input  logic [`RV_REG_ADDR_WIDTH-1:0] dec_rd_i,
  input  logic                          dec_we_i,
  input  rv_core_pkg::alu_op_e          dec_op_i,
  input  logic [`RV_DATA_WIDTH-1:0]     dec_a_i,
  input  logic [`RV_DATA_WIDTH-1:0]     dec_b_i,
  input  logic                          dec_illegal_i,
  // Bypass back to the decoder
  output logic [`RV_REG_ADDR_WIDTH-1:0] ex_fwd_rd_o,
  output logic                          ex_fwd_we_o,
  output logic [`RV_DATA_WIDTH-1:0]     ex_fwd_data_o,
  // Also the register file write port
  output logic [`RV_REG_ADDR_WIDTH-1:0] wb_fwd_rd_o,
  output logic                          wb_fwd_we_o,
  output logic [`RV_DATA_WIDTH-1:0]     wb_fwd_data_o,
  // Result record
  output logic                          res_valid_o,
  output logic [`RV_REG_ADDR_WIDTH-1:0] res_rd_o,
  output logic [`RV_DATA_WIDTH-1:0]     res_data_o,
  output logic                          res_illegal_o
);

  localparam int SHAMT_W = $clog2(`RV_DATA_WIDTH);

  logic                          ex_valid;
  logic [`RV_REG_ADDR_WIDTH-1:0] ex_rd;
  logic                          ex_we;
  rv_core_pkg::alu_op_e          ex_op;
  logic [`RV_DATA_WIDTH-1:0]     ex_a;
  logic [`RV_DATA_WIDTH-1:0]     ex_b;
  logic                          ex_illegal;
  logic [`RV_DATA_WIDTH-1:0]     alu_res;
  logic [SHAMT_W-1:0]            shamt;
  logic                          wb_valid;
  logic [`RV_REG_ADDR_WIDTH-1:0] wb_rd;
  logic                          wb_we;
  logic [`RV_DATA_WIDTH-1:0]     wb_data;
  logic                          wb_illegal;

  //////////////////////////////////////////////////
  // Execute register, loads at the end of D
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= dec_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    ex_rd      <= dec_rd_i;
    ex_we      <= dec_we_i;
    ex_op      <= dec_op_i;
    ex_a       <= dec_a_i;
    ex_b       <= dec_b_i;
    ex_illegal <= dec_illegal_i;
  end

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////
  // Shifts use the low bits of operand b only
  assign shamt = ex_b[SHAMT_W-1:0];

  always_comb begin
    case (ex_op)
      rv_core_pkg::ALU_SUB:  alu_res = ex_a - ex_b;
      rv_core_pkg::ALU_SLL:  alu_res = ex_a << shamt;
      rv_core_pkg::ALU_SLT:  alu_res = `RV_DATA_WIDTH'($signed(ex_a) < $signed(ex_b));
      rv_core_pkg::ALU_SLTU: alu_res = `RV_DATA_WIDTH'(ex_a < ex_b);
      rv_core_pkg::ALU_XOR:  alu_res = ex_a ^ ex_b;
      rv_core_pkg::ALU_SRL:  alu_res = ex_a >> shamt;
      rv_core_pkg::ALU_SRA:  alu_res = $unsigned($signed(ex_a) >>> shamt);
      rv_core_pkg::ALU_OR:   alu_res = ex_a | ex_b;
      rv_core_pkg::ALU_AND:  alu_res = ex_a & ex_b;
      default:               alu_res = ex_a + ex_b;
    endcase
  end

  // Execute-stage bypass
  assign ex_fwd_rd_o   = ex_rd;
  assign ex_fwd_we_o   = ex_valid && ex_we;
  assign ex_fwd_data_o = alu_res;

  //////////////////////////////////////////////////
  // Writeback register, loads at the end of D+1
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    wb_rd      <= ex_rd;
    wb_we      <= ex_we;
    wb_data    <= alu_res;
    wb_illegal <= ex_illegal;
  end

  // Register file write takes effect at the end of D+2
  assign wb_fwd_rd_o   = wb_rd;
  assign wb_fwd_we_o   = wb_valid && wb_we;
  assign wb_fwd_data_o = wb_data;

  // One record per instruction, slot was reserved at issue
  assign res_valid_o   = wb_valid;
  assign res_rd_o      = wb_rd;
  assign res_data_o    = wb_data;
  assign res_illegal_o = wb_valid && wb_illegal;

endmodule

// File: hw/rv_issue_queue.sv
// Credit-controlled instruction queue feeding the decoder
// Also holds the result credit count that gates issue
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_issue_queue (
  input  logic        clk_i,
  input  logic        rstn_i,
  // Instruction stream from the sender
  input  logic        instr_valid_i,
  input  logic [31:0] instr_i,
  output logic        instr_credit_o,
  // Result credits from the consumer
  input  logic        res_credit_i,
  // Issue to the decoder
  output logic        issue_valid_o,
  output logic [31:0] issue_instr_o
);

  localparam int PTR_W = (`RV_QUEUE_DEPTH > 1) ? $clog2(`RV_QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(`RV_QUEUE_DEPTH + 1);
  localparam int CRD_W = $clog2(`RV_RES_CREDITS + 1);

  logic [31:0]      mem [`RV_QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CRD_W-1:0] res_cnt;
  logic             issue;

  // Circular pointer advance with explicit wrap
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(`RV_QUEUE_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Need an entry plus a free result slot
  assign issue          = (count != '0) && (res_cnt != '0);
  assign issue_valid_o  = issue;
  assign issue_instr_o  = mem[rd_ptr];
  // Entry leaves the queue, its slot goes back to the sender
  assign instr_credit_o = issue;

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      mem[wr_ptr] <= instr_i;
    end
  end

  // Pointers and occupancy
  // Sender never overruns, it only sends with a credit in hand
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (instr_valid_i) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (issue) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + CNT_W'(instr_valid_i) - CNT_W'(issue);
    end
  end

  // Result credits, spent on issue and returned by the consumer
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      res_cnt <= CRD_W'(`RV_RES_CREDITS);
    end else begin
      res_cnt <= res_cnt - CRD_W'(issue) + CRD_W'(res_credit_i);
    end
  end

endmodule

// File: hw/rv_regfile.sv
// Integer register file, two combinational reads and one write
// x0 is hardwired to zero by dropping writes to it
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_regfile (
  input  logic                          clk_i,
  input  logic                          rstn_i,
  // Read port A
  input  logic [`RV_REG_ADDR_WIDTH-1:0] rpa_addr_i,
  output logic [`RV_DATA_WIDTH-1:0]     rpa_data_o,
  // Read port B
  input  logic [`RV_REG_ADDR_WIDTH-1:0] rpb_addr_i,
  output logic [`RV_DATA_WIDTH-1:0]     rpb_data_o,
  // Write port C
  input  logic [`RV_REG_ADDR_WIDTH-1:0] wpc_addr_i,
  input  logic [`RV_DATA_WIDTH-1:0]     wpc_data_i,
  input  logic                          wpc_we_i
);

  localparam int NUM_REGS = 1 << `RV_REG_ADDR_WIDTH;

  // x0..x31
  logic [`RV_DATA_WIDTH-1:0] regs [NUM_REGS];

  // Whole array cleared on reset, x0 never written afterwards
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wpc_we_i && (wpc_addr_i != '0)) begin
      regs[wpc_addr_i] <= wpc_data_i;
    end
  end

  // Plain array reads, same-cycle writes are covered by decoder bypass
  assign rpa_data_o = regs[rpa_addr_i];
  assign rpb_data_o = regs[rpb_addr_i];

endmodule

// File: project.f
+incdir+hw
hw/rv_core_pkg.sv
hw/rv_regfile.sv
hw/rv_issue_queue.sv
hw/rv_decoder.sv
hw/rv_execute.sv
hw/rv_exec_top.sv
dv/tb_rv_exec.sv
